// File: verilog/net_pkg.sv
/*
  Shared definitions for the network controller's address acquisition.
  Holds the timing constants, the vector types with a meaning, the
  grouped signal structs and the address FSM state encoding.
  Every design file refers to these with net_pkg:: scoped names.
*/
package net_pkg;

  // --------------------
  // plain vector types
  // --------------------
  typedef logic [31:0] ip_addr_t;
  typedef logic [47:0] mac_addr_t;
  // lease and window counts, up to 262143 s
  typedef logic [17:0] seconds_t;
  typedef logic [31:0] lease_t;
  // seconds since the first discover
  typedef logic [3:0]  elapsed_t;
  typedef logic [26:0] cycles_t;

  // --------------------
  // timing constants
  // --------------------
  // tx_clock rate at 1 Gb
  localparam int       CYCLES_PER_SECOND = 125_000_000;
  // 12 hours when the server gives no lease
  localparam seconds_t DEFAULT_RENEW_S   = 18'd43_200;
  localparam seconds_t RENEW_ACK_S       = 18'd20;
  localparam seconds_t RENEW_RETRY_S     = 18'd300;
  localparam elapsed_t GIVE_UP_S         = 4'd15;
  // discover resent at these elapsed seconds
  localparam elapsed_t RETRY_AT_1        = 4'd1;
  localparam elapsed_t RETRY_AT_3        = 4'd3;
  localparam elapsed_t RETRY_AT_7        = 4'd7;
  // link-local 169.254.x.x
  localparam logic [15:0] APIPA_PREFIX   = {8'd169, 8'd254};

  // --------------------
  // grouped signals
  // --------------------
  // speed 10 = 1 Gb, 01 = 100 Mb
  typedef struct packed {
    logic [1:0] speed;
    logic       duplex;
  } phy_status_t;

  typedef struct packed {
    logic use_static;
    logic static_fallback;
  } net_config_t;

  typedef struct packed {
    logic up;
    logic settled;
    logic speed_1gb;
  } link_state_t;

  // offer and lease only valid with success
  typedef struct packed {
    logic     success;
    ip_addr_t offer;
    lease_t   lease;
  } dhcp_result_t;

  typedef struct packed {
    logic     load;
    seconds_t value;
  } lease_cmd_t;

  typedef enum logic [2:0] {
    st_link_wait,
    st_settle,
    st_discover,
    st_wait_offer,
    st_fixed,
    st_bound,
    st_renew_req,
    st_renew_ack
  } addr_state_e;

endpackage

// File: verilog/second_tick.sv
/*
  One-second prescaler on tx_clock.
  Strobes tick for one cycle every CYCLES_PER_SECOND cycles, counted
  from the release of reset. Simulation lowers the rate via the parameter.
*/
`timescale 1ns/1ps

module second_tick #(
  parameter int CYCLES_PER_SECOND = net_pkg::CYCLES_PER_SECOND
) (
  input  logic tx_clock,
  input  logic rst_n,
  output logic tick
);

  // cycles within the current second
  net_pkg::cycles_t count;

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == net_pkg::cycles_t'(CYCLES_PER_SECOND - 1)) begin
      // last cycle of the second, wrap and strobe
      count <= '0;
      tick  <= 1'b1;
    end else begin
      count <= count + net_pkg::cycles_t'(1);
      tick  <= 1'b0;
    end
  end

endmodule

// File: verilog/link_monitor.sv
/*
  PHY link watcher.
  Registers link good from the PHY speed and duplex, latches the speed
  as the link comes up and raises settled once a whole second has gone by.
  A dropped link clears everything at once.
*/
`timescale 1ns/1ps

module link_monitor (
  input  logic                 tx_clock,
  input  logic                 rst_n,
  input  logic                 tick,
  input  net_pkg::phy_status_t phy,
  output net_pkg::link_state_t link
);

  // full duplex and exactly one speed bit set
  logic link_good;
  // first tick after up seen, second ends the settle
  logic seen_tick;

  assign link_good = phy.duplex && (phy.speed[1] != phy.speed[0]);

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      link      <= '0;
      seen_tick <= 1'b0;
    end else if (!link_good) begin
      // loss clears up and settled on the same edge
      link.up      <= 1'b0;
      link.settled <= 1'b0;
      seen_tick    <= 1'b0;
    end else begin
      link.up <= 1'b1;
      // rising edge of up, capture the speed
      if (!link.up) begin
        link.speed_1gb <= phy.speed[1];
      end
      // ticks only count once up is registered
      if (link.up && tick) begin
        if (seen_tick) begin
          link.settled <= 1'b1;
        end else begin
          seen_tick <= 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/lease_timer.sv
/*
  Loadable seconds countdown.
  The address FSM loads it for the renewal wait, the ACK window and
  the pause between renewal attempts. expired stays high while the
  count sits at zero, so the FSM samples it as a level.
*/
`timescale 1ns/1ps

module lease_timer (
  input  logic                tx_clock,
  input  logic                rst_n,
  input  logic                tick,
  input  net_pkg::lease_cmd_t cmd,
  output logic                expired
);

  // seconds left in the current window
  net_pkg::seconds_t count;

  // --------------------
  // countdown
  // --------------------
  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      count <= '0;
    end else if (cmd.load) begin
      // a load wins over a tick in the same cycle
      count <= cmd.value;
    end else if (tick && (count != '0)) begin
      count <= count - net_pkg::seconds_t'(1);
    end
  end

  // --------------------
  // status
  // --------------------
  // holds at zero until the next load
  assign expired = (count == '0);

endmodule

// File: verilog/address_fsm.sv
/*
  Address acquisition and lease renewal FSM.
  Combines the link state and the lease timer with the configuration
  bits to pick a static, DHCP or link-local address. Talks to the
  external DHCP engine with single-cycle request and success strobes.
*/
`timescale 1ns/1ps

module address_fsm (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  logic                  tick,
  input  net_pkg::link_state_t  link,
  input  logic                  lease_expired,
  input  net_pkg::net_config_t  cfg,
  input  net_pkg::ip_addr_t     static_ip,
  input  net_pkg::mac_addr_t    local_mac,
  input  net_pkg::dhcp_result_t dhcp,
  output net_pkg::lease_cmd_t   lease_cmd,
  output logic                  dhcp_tx_request,
  output logic                  dhcp_rx_enable,
  output logic                  ip_valid,
  output net_pkg::ip_addr_t     local_ip,
  output net_pkg::elapsed_t     dhcp_seconds
);

  net_pkg::addr_state_e state;
  // elapsed count after this tick
  net_pkg::elapsed_t    next_seconds;
  // renewal wait from the offered lease
  net_pkg::seconds_t    renew_s;
  // timer holds its old count while a load is in flight
  logic                 window_done;

  assign next_seconds = dhcp_seconds + net_pkg::elapsed_t'(1);
  assign window_done  = lease_expired && !lease_cmd.load;

  // half the lease saturated to the timer width
  always_comb begin
    if (dhcp.lease == '0) begin
      renew_s = net_pkg::DEFAULT_RENEW_S;
    end else if (|dhcp.lease[31:19]) begin
      renew_s = '1;
    end else begin
      renew_s = dhcp.lease[18:1];
    end
  end

  always_ff @(posedge tx_clock) begin
    if (!rst_n) begin
      state           <= net_pkg::st_link_wait;
      lease_cmd       <= '0;
      dhcp_tx_request <= 1'b0;
      dhcp_rx_enable  <= 1'b0;
      ip_valid        <= 1'b0;
      local_ip        <= '0;
      dhcp_seconds    <= '0;
    end else begin
      // strobes last one cycle
      dhcp_tx_request <= 1'b0;
      lease_cmd.load  <= 1'b0;

      if ((state != net_pkg::st_link_wait) && !link.up) begin
        // link lost so start over
        state          <= net_pkg::st_link_wait;
        ip_valid       <= 1'b0;
        dhcp_rx_enable <= 1'b0;
      end else begin
        case (state)
          net_pkg::st_link_wait: begin
            if (link.up) begin
              state <= net_pkg::st_settle;
            end
          end

          // --------------------
          // address choice
          // --------------------
          net_pkg::st_settle: begin
            if (link.settled) begin
              if (cfg.use_static && !cfg.static_fallback) begin
                local_ip <= static_ip;
                ip_valid <= 1'b1;
                state    <= net_pkg::st_fixed;
              end else begin
                // DHCP needs 0.0.0.0 as source
                local_ip     <= '0;
                dhcp_seconds <= '0;
                state        <= net_pkg::st_discover;
              end
            end
          end

          net_pkg::st_discover: begin
            dhcp_tx_request <= 1'b1;
            dhcp_rx_enable  <= 1'b1;
            state           <= net_pkg::st_wait_offer;
          end

          net_pkg::st_wait_offer: begin
            if (dhcp.success) begin
              local_ip        <= dhcp.offer;
              ip_valid        <= 1'b1;
              dhcp_rx_enable  <= 1'b0;
              dhcp_seconds    <= '0;
              lease_cmd.load  <= 1'b1;
              lease_cmd.value <= renew_s;
              state           <= net_pkg::st_bound;
            end else if (tick) begin
              dhcp_seconds <= next_seconds;
              if ((next_seconds == net_pkg::RETRY_AT_1) ||
                  (next_seconds == net_pkg::RETRY_AT_3) ||
                  (next_seconds == net_pkg::RETRY_AT_7)) begin
                state <= net_pkg::st_discover;
              end else if (next_seconds == net_pkg::GIVE_UP_S) begin
                // no offer so static if allowed else link-local
                if (cfg.static_fallback) begin
                  local_ip <= static_ip;
                end else begin
                  local_ip <= {net_pkg::APIPA_PREFIX, local_mac[15:0]};
                end
                ip_valid       <= 1'b1;
                dhcp_rx_enable <= 1'b0;
                state          <= net_pkg::st_fixed;
              end
            end
          end

          // static or link-local held until link loss
          net_pkg::st_fixed: begin
          end

          // --------------------
          // lease renewal
          // --------------------
          net_pkg::st_bound: begin
            if (window_done) begin
              state <= net_pkg::st_renew_req;
            end
          end

          net_pkg::st_renew_req: begin
            dhcp_tx_request <= 1'b1;
            dhcp_rx_enable  <= 1'b1;
            lease_cmd.load  <= 1'b1;
            lease_cmd.value <= net_pkg::RENEW_ACK_S;
            state           <= net_pkg::st_renew_ack;
          end

          net_pkg::st_renew_ack: begin
            if (dhcp.success) begin
              // address kept and only the lease refreshed
              lease_cmd.load  <= 1'b1;
              lease_cmd.value <= renew_s;
              dhcp_rx_enable  <= 1'b0;
              state           <= net_pkg::st_bound;
            end else if (window_done) begin
              // no ACK so pause before the next try
              lease_cmd.load  <= 1'b1;
              lease_cmd.value <= net_pkg::RENEW_RETRY_S;
              dhcp_rx_enable  <= 1'b0;
              state           <= net_pkg::st_bound;
            end
          end

          default: begin
            state <= net_pkg::st_link_wait;
          end
        endcase
      end
    end
  end

endmodule

// File: verilog/network_ctrl.sv
/*
  Network controller top level, address acquisition only.
  Ties the second tick, the link monitor and the lease timer to the
  address FSM. The DHCP engine sits outside and talks through the
  request and success strobes.
*/
`timescale 1ns/1ps

module network_ctrl #(
  parameter int CYCLES_PER_SECOND = net_pkg::CYCLES_PER_SECOND
) (
  input  logic                  tx_clock,
  input  logic                  rst_n,
  input  net_pkg::phy_status_t  phy,
  input  net_pkg::net_config_t  cfg,
  input  net_pkg::ip_addr_t     static_ip,
  input  net_pkg::mac_addr_t    local_mac,
  input  net_pkg::dhcp_result_t dhcp,
  output logic                  link_up,
  output logic                  speed_1gb,
  output logic                  ip_valid,
  output logic                  dhcp_tx_request,
  output logic                  dhcp_rx_enable,
  output net_pkg::ip_addr_t     local_ip,
  output net_pkg::elapsed_t     dhcp_seconds
);

  logic                 tick;
  net_pkg::link_state_t link;
  net_pkg::lease_cmd_t  lease_cmd;
  logic                 lease_expired;

  // --------------------
  // timing and monitors
  // --------------------
  second_tick #(
    .CYCLES_PER_SECOND(CYCLES_PER_SECOND)
  ) second_tick_inst (
    .tx_clock(tx_clock),
    .rst_n   (rst_n),
    .tick    (tick)
  );

  link_monitor link_monitor_inst (
    .tx_clock(tx_clock),
    .rst_n   (rst_n),
    .tick    (tick),
    .phy     (phy),
    .link    (link)
  );

  lease_timer lease_timer_inst (
    .tx_clock(tx_clock),
    .rst_n   (rst_n),
    .tick    (tick),
    .cmd     (lease_cmd),
    .expired (lease_expired)
  );

  // --------------------
  // address FSM
  // --------------------
  address_fsm address_fsm_inst (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .tick           (tick),
    .link           (link),
    .lease_expired  (lease_expired),
    .cfg            (cfg),
    .static_ip      (static_ip),
    .local_mac      (local_mac),
    .dhcp           (dhcp),
    .lease_cmd      (lease_cmd),
    .dhcp_tx_request(dhcp_tx_request),
    .dhcp_rx_enable (dhcp_rx_enable),
    .ip_valid       (ip_valid),
    .local_ip       (local_ip),
    .dhcp_seconds   (dhcp_seconds)
  );

  // link status out to the board
  assign link_up   = link.up;
  assign speed_1gb = link.speed_1gb;

endmodule

// File: testbench/network_ctrl_tb.sv
/*
  Testbench for the network controller's address acquisition.
  Runs static, DHCP bind, discovery timeout, renewal and link loss
  scenarios against network_ctrl with a ten-cycle second. A small
  DHCP server model answers a request after a delay or stays silent.
*/
`timescale 1ns/1ps

module network_ctrl_tb;

  // one second is ten clocks here
  localparam int TICK_CYCLES    = 10;
  localparam int TIMEOUT_CYCLES = 30_000;

  logic                  tx_clock;
  logic                  rst_n;
  net_pkg::phy_status_t  phy;
  net_pkg::net_config_t  cfg;
  net_pkg::ip_addr_t     static_ip;
  net_pkg::mac_addr_t    local_mac;
  net_pkg::dhcp_result_t dhcp;
  logic                  link_up;
  logic                  speed_1gb;
  logic                  ip_valid;
  logic                  dhcp_tx_request;
  logic                  dhcp_rx_enable;
  net_pkg::ip_addr_t     local_ip;
  net_pkg::elapsed_t     dhcp_seconds;

  int cycle_count;
  int fail_count;
  int strobe_fail_count;
  int link_fail_count;
  int test_count;
  // cycle numbers of every request strobe
  int request_cycles[$];

  network_ctrl #(
    .CYCLES_PER_SECOND(TICK_CYCLES)
  ) network_ctrl_inst (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .phy            (phy),
    .cfg            (cfg),
    .static_ip      (static_ip),
    .local_mac      (local_mac),
    .dhcp           (dhcp),
    .link_up        (link_up),
    .speed_1gb      (speed_1gb),
    .ip_valid       (ip_valid),
    .dhcp_tx_request(dhcp_tx_request),
    .dhcp_rx_enable (dhcp_rx_enable),
    .local_ip       (local_ip),
    .dhcp_seconds   (dhcp_seconds)
  );

  // 40 ns period
  always #20 tx_clock = ~tx_clock;

  // --------------------
  // cycle counter with timeout and request log
  // --------------------
  always @(posedge tx_clock) begin
    if (rst_n && dhcp_tx_request) begin
      request_cycles.push_back(cycle_count);
    end
  end

  always @(posedge tx_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // request is a one-cycle strobe
  assert property (@(posedge tx_clock) disable iff (!rst_n)
                   dhcp_tx_request |=> !dhcp_tx_request)
    else begin
      strobe_fail_count++;
      $display("request strobe held longer than one cycle at cycle %0d", cycle_count);
    end

  // no address survives a lost link
  assert property (@(posedge tx_clock) disable iff (!rst_n)
                   !link_up |=> !ip_valid)
    else begin
      link_fail_count++;
      $display("ip_valid still high after link loss at cycle %0d", cycle_count);
    end

  // --------------------
  // checks
  // --------------------
  function automatic int total_fails();
    return fail_count + strobe_fail_count + link_fail_count;
  endfunction

  task automatic check_ip(input string test, input string what,
                          input net_pkg::ip_addr_t expected, input net_pkg::ip_addr_t actual);
    assert (actual === expected)
      else begin
        fail_count++;
        $display("CHECK FAILED %s: %s expected %h actual %h", test, what, expected, actual);
      end
  endtask

  task automatic check_bit(input string test, input string what,
                           input logic expected, input logic actual);
    assert (actual === expected)
      else begin
        fail_count++;
        $display("CHECK FAILED %s: %s expected %b actual %b", test, what, expected, actual);
      end
  endtask

  task automatic check_range(input string test, input string what,
                             input int lo, input int hi, input int actual);
    assert ((actual >= lo) && (actual <= hi))
      else begin
        fail_count++;
        $display("CHECK FAILED %s: %s expected %0d..%0d actual %0d", test, what, lo, hi,
                 actual);
      end
  endtask

  // --------------------
  // stepping and waiting
  // --------------------
  // outputs settled and inputs safe to drive 1 ns past the edge
  task automatic next_cycle();
    @(posedge tx_clock);
    #1;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) next_cycle();
  endtask

  task automatic wait_request(input string test, input int limit, output int at_cycle);
    int waited;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!dhcp_tx_request && (waited < limit));
    at_cycle = cycle_count;
    assert (dhcp_tx_request)
      else begin
        fail_count++;
        $display("%s: no DHCP request came within %0d cycles", test, limit);
      end
  endtask

  task automatic wait_ip_valid(input string test, input int limit, output int at_cycle);
    int waited;
    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (!ip_valid && (waited < limit));
    at_cycle = cycle_count;
    assert (ip_valid)
      else begin
        fail_count++;
        $display("%s: no valid address within %0d cycles", test, limit);
      end
  endtask

  // DHCP server model that stays silent when answer is clear
  task automatic serve_request(input string test, input bit answer, input int delay,
                               input net_pkg::ip_addr_t offer, input net_pkg::lease_t lease,
                               input int limit, output int request_at);
    wait_request(test, limit, request_at);
    if (answer) begin
      idle(delay);
      dhcp.success = 1'b1;
      dhcp.offer   = offer;
      dhcp.lease   = lease;
      next_cycle();
      dhcp = '0;
    end
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    phy   = '0;
    dhcp  = '0;
    idle(3);
    rst_n = 1'b1;
    request_cycles.delete();
  endtask

  task automatic link_1gb();
    phy.speed  = 2'b10;
    phy.duplex = 1'b1;
  endtask

  task automatic finish_test(input string test, input int fails_before);
    test_count++;
    $display("test %-9s %s, %0d errors", test,
             (total_fails() == fails_before) ? "ok" : "failed", total_fails() - fails_before);
  endtask

  // --------------------
  // scenarios
  // --------------------
  task automatic test_static();
    int fails_before;
    int start;
    int seen_at;
    fails_before = total_fails();
    reset_dut();
    cfg.use_static      = 1'b1;
    cfg.static_fallback = 1'b0;
    link_1gb();
    start = cycle_count;
    wait_ip_valid("static", 4 * TICK_CYCLES, seen_at);
    // at least one whole settle second
    check_range("static", "settle delay", TICK_CYCLES + 1, 3 * TICK_CYCLES, seen_at - start);
    check_ip("static", "local_ip", static_ip, local_ip);
    check_bit("static", "link_up", 1'b1, link_up);
    check_bit("static", "speed_1gb", 1'b1, speed_1gb);
    idle(3 * TICK_CYCLES);
    check_range("static", "request count", 0, 0, request_cycles.size());
    finish_test("static", fails_before);
  endtask

  task automatic test_bind();
    int fails_before;
    int first_at;
    int seen_at;
    int renew_at;
    net_pkg::ip_addr_t offer;
    fails_before = total_fails();
    offer = $urandom;
    reset_dut();
    cfg = '0;
    link_1gb();
    serve_request("bind", 1'b1, 3, offer, 32'd12, 4 * TICK_CYCLES, first_at);
    wait_ip_valid("bind", 4, seen_at);
    check_ip("bind", "local_ip", offer, local_ip);
    check_bit("bind", "rx_enable after bind", 1'b0, dhcp_rx_enable);
    // half of 12 s counted from the first discover
    wait_request("bind", 8 * TICK_CYCLES, renew_at);
    check_range("bind", "renewal delay", 6 * TICK_CYCLES, 7 * TICK_CYCLES,
                renew_at - first_at);
    check_bit("bind", "ip_valid at renewal", 1'b1, ip_valid);
    finish_test("bind", fails_before);
  endtask

  task automatic test_give_up(input string test, input logic use_static, input logic fallback,
                              input net_pkg::ip_addr_t expected_ip);
    int fails_before;
    int first_at;
    int seen_at;
    fails_before = total_fails();
    reset_dut();
    cfg.use_static      = use_static;
    cfg.static_fallback = fallback;
    link_1gb();
    wait_ip_valid(test, 20 * TICK_CYCLES, seen_at);
    // first discover then resends at 1, 3 and 7 s
    check_range(test, "request count", 4, 4, request_cycles.size());
    if (request_cycles.size() == 4) begin
      first_at = request_cycles[0];
      check_range(test, "resend at 1 s", 0, 2 * TICK_CYCLES, request_cycles[1] - first_at);
      check_range(test, "resend at 3 s", 2 * TICK_CYCLES, 4 * TICK_CYCLES,
                  request_cycles[2] - first_at);
      check_range(test, "resend at 7 s", 6 * TICK_CYCLES, 8 * TICK_CYCLES,
                  request_cycles[3] - first_at);
      check_range(test, "give up at 15 s", 14 * TICK_CYCLES, 16 * TICK_CYCLES,
                  seen_at - first_at);
    end
    check_range(test, "dhcp_seconds", 15, 15, int'(dhcp_seconds));
    check_ip(test, "local_ip", expected_ip, local_ip);
    idle(2 * TICK_CYCLES);
    check_range(test, "requests after give up", 4, 4, request_cycles.size());
    finish_test(test, fails_before);
  endtask

  task automatic test_renew();
    int fails_before;
    int first_at;
    int renew_at;
    int retry_at;
    net_pkg::ip_addr_t offer;
    fails_before = total_fails();
    offer = $urandom;
    reset_dut();
    cfg = '0;
    link_1gb();
    serve_request("renew", 1'b1, 2, offer, 32'd4, 4 * TICK_CYCLES, first_at);
    // lease 4 gives a renewal after about 2 s
    serve_request("renew", 1'b0, 0, '0, '0, 4 * TICK_CYCLES, renew_at);
    check_range("renew", "renewal delay", TICK_CYCLES + 1, 3 * TICK_CYCLES,
                renew_at - (first_at + 2));
    check_bit("renew", "rx_enable in ACK window", 1'b1, dhcp_rx_enable);
    // no ACK means a 20 s window then a 300 s pause
    serve_request("renew", 1'b0, 0, '0, '0, 330 * TICK_CYCLES, retry_at);
    check_range("renew", "retry delay", 320 * TICK_CYCLES, 321 * TICK_CYCLES,
                retry_at - renew_at);
    check_bit("renew", "ip_valid kept", 1'b1, ip_valid);
    check_ip("renew", "local_ip kept", offer, local_ip);
    finish_test("renew", fails_before);
  endtask

  task automatic test_link_loss();
    int fails_before;
    int first_at;
    int seen_at;
    int restore_at;
    int again_at;
    net_pkg::ip_addr_t offer;
    fails_before = total_fails();
    offer = $urandom;
    reset_dut();
    cfg = '0;
    link_1gb();
    serve_request("link", 1'b1, 2, offer, 32'd12, 4 * TICK_CYCLES, first_at);
    wait_ip_valid("link", 4, seen_at);
    idle(5);
    phy.duplex = 1'b0;
    idle(3);
    check_bit("link", "link_up after loss", 1'b0, link_up);
    check_bit("link", "ip_valid after loss", 1'b0, ip_valid);
    phy.duplex = 1'b1;
    restore_at = cycle_count;
    // new discover only after the settle second
    wait_request("link", 4 * TICK_CYCLES, again_at);
    check_range("link", "rediscover delay", TICK_CYCLES + 1, 3 * TICK_CYCLES,
                again_at - restore_at);
    finish_test("link", fails_before);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    net_pkg::ip_addr_t apipa_ip;
    logic [31:0]       mac_high;
    logic [31:0]       mac_low;
    tx_clock          = 1'b0;
    rst_n             = 1'b0;
    phy               = '0;
    cfg               = '0;
    dhcp              = '0;
    static_ip         = '0;
    local_mac         = '0;
    cycle_count       = 0;
    fail_count        = 0;
    strobe_fail_count = 0;
    link_fail_count   = 0;
    test_count        = 0;
    void'($urandom(32'hf5ac_5809));
    mac_high  = $urandom;
    mac_low   = $urandom;
    local_mac = {mac_high[15:0], mac_low};
    static_ip = $urandom;
    // link-local 169.254 plus low MAC bits
    apipa_ip = {8'd169, 8'd254, local_mac[15:0]};

    test_static();
    test_bind();
    test_give_up("apipa", 1'b0, 1'b0, apipa_ip);
    test_give_up("fallback", 1'b1, 1'b1, static_ip);
    test_renew();
    test_link_loss();

    $display("%0d tests run, %0d checks failed", test_count, total_fails());
    if (total_fails() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: network_ctrl.f
verilog/net_pkg.sv
verilog/second_tick.sv
verilog/link_monitor.sv
verilog/lease_timer.sv
verilog/address_fsm.sv
verilog/network_ctrl.sv
testbench/network_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the network controller testbench

TOP := network_ctrl_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): network_ctrl.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert -f network_ctrl.f --top-module $(TOP)

# pass or fail decided by the log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f network_ctrl.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
